/* hdl/cache_pkg.sv */
package cache_pkg;

  // address split: low bits pick the line, the rest is the tag
  localparam int addr_bits   = 10;
  localparam int index_bits  = 3;
  localparam int tag_bits    = addr_bits - index_bits;
  localparam int data_bits   = 32;
  localparam int num_lines   = 2 ** index_bits;

  // edges from a sampled memory request to its ack
  localparam int mem_latency = 3;

  typedef logic [addr_bits-1:0]  addr_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [data_bits-1:0]  data_t;

  // requester side
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } cpu_req_t;

  typedef struct packed {
    data_t rdata;
    logic  hit;
  } cpu_rsp_t;

  // memory side
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

endpackage

/* hdl/line_array.sv */
module line_array (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t lookup_addr,
  input  logic             fill,
  input  cache_pkg::data_t fill_data,
  output logic             lookup_hit,
  output cache_pkg::data_t lookup_data
);
  import cache_pkg::*;

  index_t               index;
  tag_t                 tag;
  logic [num_lines-1:0] line_we;
  logic [num_lines-1:0] line_valid;
  tag_t                 line_tag  [num_lines];
  data_t                line_data [num_lines];

  assign index = lookup_addr[index_bits-1:0];
  assign tag   = lookup_addr[addr_bits-1:index_bits];

  // one write enable per line
  always_comb begin
    line_we        = '0;
    line_we[index] = fill;
  end

  // valid bits are the only state that needs clearing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      line_valid <= '0;
    end else begin
      for (int i = 0; i < num_lines; i++) begin
        if (line_we[i]) begin
          line_valid[i] <= 1'b1;
        end
      end
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_lines; i++) begin
      if (line_we[i]) begin
        line_tag[i]  <= tag;
        line_data[i] <= fill_data;
      end
    end
  end

  // zero-cycle lookup on the selected line
  assign lookup_hit  = line_valid[index] && (line_tag[index] == tag);
  assign lookup_data = line_data[index];

endmodule

/* hdl/cache_ctrl.sv */
module cache_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cpu_req_valid,
  input  cache_pkg::cpu_req_t cpu_req,
  output logic                cpu_ack,
  output cache_pkg::cpu_rsp_t cpu_rsp,
  output cache_pkg::addr_t    lookup_addr,
  output logic                fill,
  output cache_pkg::data_t    fill_data,
  input  logic                lookup_hit,
  input  cache_pkg::data_t    lookup_data,
  output logic                mem_req_valid,
  output cache_pkg::mem_req_t mem_req,
  input  logic                mem_ack,
  input  cache_pkg::data_t    mem_rdata
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_mem_req,
    st_mem_release,
    st_respond,
    st_release
  } ctrl_state_t;

  ctrl_state_t state;
  logic        fill_q;

  // request and response payload
  cpu_req_t    req_q;
  data_t       data_q;
  logic        hit_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_idle;
      fill_q <= 1'b0;
    end else begin
      fill_q <= 1'b0;
      case (state)
        st_idle: begin
          if (cpu_req_valid) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          // only a read hit skips the memory
          if (!req_q.write && lookup_hit) begin
            state <= st_respond;
          end else begin
            state <= st_mem_req;
          end
        end
        st_mem_req: begin
          if (mem_ack) begin
            state <= st_mem_release;
          end
        end
        st_mem_release: begin
          // memory handshake done, write the line once
          if (!mem_ack) begin
            fill_q <= 1'b1;
            state  <= st_respond;
          end
        end
        st_respond: begin
          if (!cpu_req_valid) begin
            state <= st_idle;
          end else begin
            state <= st_release;
          end
        end
        st_release: begin
          // hold ack until the requester lets go
          if (!cpu_req_valid) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (cpu_req_valid) begin
          req_q <= cpu_req;
        end
      end
      st_lookup: begin
        // hit reflects the line before any fill
        hit_q  <= lookup_hit;
        data_q <= lookup_data;
      end
      st_mem_req: begin
        if (mem_ack) begin
          data_q <= req_q.write ? req_q.wdata : mem_rdata;
        end
      end
      default: begin
      end
    endcase
  end

  // line array side
  assign lookup_addr = req_q.addr;
  assign fill        = fill_q;
  assign fill_data   = data_q;

  // requester side
  assign cpu_ack       = (state == st_respond) || (state == st_release);
  assign cpu_rsp.rdata = data_q;
  assign cpu_rsp.hit   = hit_q;

  // memory side, payload held from the registered request
  assign mem_req_valid = (state == st_mem_req);
  assign mem_req.write = req_q.write;
  assign mem_req.addr  = req_q.addr;
  assign mem_req.wdata = req_q.wdata;

endmodule

/* hdl/backing_mem.sv */
module backing_mem (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_req_valid,
  input  cache_pkg::mem_req_t mem_req,
  output logic                mem_ack,
  output cache_pkg::data_t    mem_rdata
);
  import cache_pkg::*;

  data_t mem [2 ** addr_bits];

  logic [$clog2(mem_latency + 1)-1:0] delay_cnt;
  logic                               ack_rise;

  // last cycle of the delay
  assign ack_rise = mem_req_valid && !mem_ack &&
                    (delay_cnt == ($bits(delay_cnt))'(mem_latency));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_ack   <= 1'b0;
      delay_cnt <= '0;
    end else if (!mem_req_valid) begin
      // req dropped, release ack and rearm
      mem_ack   <= 1'b0;
      delay_cnt <= '0;
    end else if (ack_rise) begin
      mem_ack <= 1'b1;
    end else if (!mem_ack) begin
      delay_cnt <= delay_cnt + 1'b1;
    end
  end

  // array access happens together with the rising ack
  always_ff @(posedge clk) begin
    if (ack_rise) begin
      if (mem_req.write) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end else begin
        mem_rdata <= mem[mem_req.addr];
      end
    end
  end

endmodule

/* hdl/cache_top.sv */
module cache_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cpu_req_valid,
  input  cache_pkg::cpu_req_t cpu_req,
  output logic                cpu_ack,
  output cache_pkg::cpu_rsp_t cpu_rsp
);
  import cache_pkg::*;

  // controller to line array
  addr_t    lookup_addr;
  logic     fill;
  data_t    fill_data;
  logic     lookup_hit;
  data_t    lookup_data;

  // controller to memory
  logic     mem_req_valid;
  mem_req_t mem_req;
  logic     mem_ack;
  data_t    mem_rdata;

  cache_ctrl u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_ack       (cpu_ack),
    .cpu_rsp       (cpu_rsp),
    .lookup_addr   (lookup_addr),
    .fill          (fill),
    .fill_data     (fill_data),
    .lookup_hit    (lookup_hit),
    .lookup_data   (lookup_data),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  line_array u_lines (
    .clk         (clk),
    .arst_n      (arst_n),
    .lookup_addr (lookup_addr),
    .fill        (fill),
    .fill_data   (fill_data),
    .lookup_hit  (lookup_hit),
    .lookup_data (lookup_data)
  );

  backing_mem u_mem (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

endmodule

/* tests/cache_assert.sv */
module cache_assert (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cpu_req_valid,
  input  cache_pkg::cpu_req_t cpu_req,
  input  logic                cpu_ack,
  input  cache_pkg::cpu_rsp_t cpu_rsp,
  input  logic                mem_req_valid,
  input  logic                mem_ack
);
  import cache_pkg::*;

  int unsigned fail_count = 0;

  // reference model of the lines and of every written word
  logic                      ack_q;
  logic [num_lines-1:0]      model_valid;
  tag_t                      model_tag [num_lines];
  logic [2**addr_bits-1:0]   written;
  data_t                     shadow [2**addr_bits];

  index_t req_index;
  tag_t   req_tag;
  logic   exp_hit;
  logic   exp_known;
  data_t  exp_data;
  logic   ack_first;

  assign req_index = cpu_req.addr[index_bits-1:0];
  assign req_tag   = cpu_req.addr[addr_bits-1:index_bits];
  assign exp_hit   = model_valid[req_index] && (model_tag[req_index] == req_tag);
  assign exp_known = written[cpu_req.addr];
  assign exp_data  = shadow[cpu_req.addr];
  assign ack_first = cpu_ack && !ack_q;

  // every access allocates its line
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q       <= 1'b0;
      model_valid <= '0;
      written     <= '0;
    end else begin
      ack_q <= cpu_ack;
      if (ack_first) begin
        model_valid[req_index] <= 1'b1;
        if (cpu_req.write) begin
          written[cpu_req.addr] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arst_n && ack_first) begin
      model_tag[req_index] <= req_tag;
      if (cpu_req.write) begin
        shadow[cpu_req.addr] <= cpu_req.wdata;
      end
    end
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    !cpu_req_valid |=> !cpu_ack)
    else begin
      fail_count++;
      $error("cpu_ack high one cycle after req was low");
    end

  ack_held: assert property (@(posedge clk) disable iff (!arst_n)
    cpu_ack && cpu_req_valid |=> cpu_ack && (cpu_rsp === $past(cpu_rsp)))
    else begin
      fail_count++;
      $error("cpu_ack or cpu_rsp changed while req was still high");
    end

  hit_flag: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cpu_ack) |-> cpu_rsp.hit == exp_hit)
    else begin
      fail_count++;
      $error("Fail cpu_rsp.hit: got %h expected %h", $sampled(cpu_rsp.hit), $sampled(exp_hit));
    end

  read_data: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cpu_ack) && !cpu_req.write && exp_known |-> cpu_rsp.rdata === exp_data)
    else begin
      fail_count++;
      $error("Fail cpu_rsp.rdata: got %h expected %h",
             $sampled(cpu_rsp.rdata), $sampled(exp_data));
    end

  mem_ack_release: assert property (@(posedge clk) disable iff (!arst_n)
    !mem_req_valid |=> !mem_ack)
    else begin
      fail_count++;
      $error("mem_ack high one cycle after mem req was low");
    end

  mem_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(mem_ack) |-> mem_req_valid)
    else begin
      fail_count++;
      $error("mem_ack rose without a memory request");
    end

endmodule

bind cache_top cache_assert u_check (
  .clk           (clk),
  .arst_n        (arst_n),
  .cpu_req_valid (cpu_req_valid),
  .cpu_req       (cpu_req),
  .cpu_ack       (cpu_ack),
  .cpu_rsp       (cpu_rsp),
  .mem_req_valid (mem_req_valid),
  .mem_ack       (mem_ack)
);

/* tests/cache_tb.sv */
module cache_tb;
  import cache_pkg::*;

  localparam int ack_timeout = 100;
  localparam int num_random  = 200;

  logic     clk;
  logic     arst_n;
  logic     cpu_req_valid;
  cpu_req_t cpu_req;
  logic     cpu_ack;
  cpu_rsp_t cpu_rsp;

  integer   seed;
  int       tests_run;
  int       tests_failed;
  int       timeouts;
  int       fails_at_start;
  int       timeouts_at_start;

  // addresses written so far, for the random reads
  addr_t                   written_list[$];
  logic [2**addr_bits-1:0] listed;

  cache_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_ack       (cpu_ack),
    .cpu_rsp       (cpu_rsp)
  );

  always #20 clk = ~clk;

  // one four-phase transaction, extra_hold keeps req up after ack
  task automatic access(input logic write, input addr_t addr, input data_t wdata,
                        input int extra_hold);
    int n;
    cpu_req.write = write;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    cpu_req_valid = 1'b1;
    n = 0;
    while (!cpu_ack && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_ack) begin
      $display("timeout: no cpu_ack for access to address %h", addr);
      timeouts++;
    end
    repeat (extra_hold) @(negedge clk);
    cpu_req_valid = 1'b0;
    n = 0;
    while (cpu_ack && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    if (cpu_ack) begin
      $display("timeout: cpu_ack stays high after req dropped, address %h", addr);
      timeouts++;
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t wdata);
    access(1'b1, addr, wdata, 0);
    if (!listed[addr]) begin
      listed[addr] = 1'b1;
      written_list.push_back(addr);
    end
  endtask

  task automatic read_word(input addr_t addr);
    access(1'b0, addr, '0, 0);
  endtask

  task automatic start_test();
    fails_at_start    = dut.u_check.fail_count;
    timeouts_at_start = timeouts;
  endtask

  task automatic finish_test(input string name);
    int new_fails;
    int new_timeouts;
    new_fails    = dut.u_check.fail_count - fails_at_start;
    new_timeouts = timeouts - timeouts_at_start;
    tests_run++;
    if (new_fails == 0 && new_timeouts == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d assertion failures, %0d timeouts",
               tests_run, name, new_fails, new_timeouts);
    end
  endtask

  // random writes over a small tag range so that reads hit and miss
  task automatic random_mix();
    logic [31:0] r;
    addr_t       a;
    for (int i = 0; i < num_random; i++) begin
      r = $random(seed);
      if (written_list.size() == 0 || r[0]) begin
        a = {5'd0, r[5:4], r[3:1]};
        write_word(a, $random(seed));
      end else begin
        a = written_list[r[31:8] % written_list.size()];
        read_word(a);
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    listed        = '0;
    seed          = 49;
    tests_run     = 0;
    tests_failed  = 0;
    timeouts      = 0;

    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // idle cycles, then first reads on every index
    start_test();
    repeat (8) @(negedge clk);
    for (int i = 0; i < num_lines; i++) begin
      read_word(10'h200 + 10'(i));
    end
    finish_test("reset and first reads");

    start_test();
    access(1'b0, 10'h201, '0, 5);
    repeat (3) @(negedge clk);
    access(1'b1, 10'h041, 32'h1357_9bdf, 3);
    access(1'b0, 10'h041, '0, 4);
    finish_test("handshake with held req");

    start_test();
    write_word(10'h0a5, 32'hcafe_0a05);
    read_word(10'h0a5);
    finish_test("write then read");

    // same index, other tag evicts the first line
    start_test();
    write_word(10'h1a5, 32'h5a5a_1a05);
    read_word(10'h0a5);
    read_word(10'h1a5);
    finish_test("conflict on one index");

    start_test();
    read_word(10'h2f3);
    read_word(10'h2f3);
    finish_test("read miss then hit");

    start_test();
    random_mix();
    finish_test("random mix");

    $display("tests %0d, failed %0d, assertion failures %0d, timeouts %0d",
             tests_run, tests_failed, dut.u_check.fail_count, timeouts);
    if (tests_failed == 0 && dut.u_check.fail_count == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/cache_pkg.sv
hdl/line_array.sv
hdl/cache_ctrl.sv
hdl/backing_mem.sv
hdl/cache_top.sv
tests/cache_assert.sv
tests/cache_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f src.f
	@out=$$(./obj_dir/Vcache_tb +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
